// File: hw/uart_pkg.sv
package uart_pkg;

  // One host command: [15] write flag, [14:8] address, [7:0] write data
  typedef logic [15:0] cmd_t;

  // Serial payload and read data
  typedef logic [7:0] byte_t;

  typedef logic [6:0] addr_t;

  typedef enum logic [2:0] {
    idle,
    send_cmd,
    gap,
    send_data,
    wait_reply,
    done
  } ctrl_state_t;

  // Start, eight data bits, parity and stop
  localparam int frame_bits = 11;

endpackage

// File: hw/uart_phy_if.sv
`timescale 1ns/1ps

interface uart_phy_if;

  logic            tx_start;
  uart_pkg::byte_t tx_byte;
  logic            tx_busy;
  logic            rx_arm;
  logic            rx_done;
  uart_pkg::byte_t rx_byte;
  logic            rx_bad;

  modport ctrl (
    output tx_start,
    output tx_byte,
    output rx_arm,
    input  tx_busy,
    input  rx_done,
    input  rx_byte,
    input  rx_bad
  );

  modport tx (
    input  tx_start,
    input  tx_byte,
    output tx_busy
  );

  modport rx (
    input  rx_arm,
    output rx_done,
    output rx_byte,
    output rx_bad
  );

endinterface

// File: hw/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  uart_pkg::cmd_t cmd_in,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  output uart_pkg::cmd_t cmd_head,
  output logic           cmd_avail,
  input  logic           cmd_pop
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  uart_pkg::cmd_t   mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  assign cmd_rdy   = (count != cnt_w'(fifo_depth));
  assign cmd_avail = (count != '0);
  assign cmd_head  = mem[rd_ptr];
  assign push      = cmd_vld && cmd_rdy;
  assign pop       = cmd_pop && cmd_avail;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap at fifo_depth, which need not be a power of two
      if (push)
      begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int bit_period = 434
) (
  input  logic   clk,
  input  logic   rst_n,
  uart_phy_if.tx phy,
  output logic   tx
);

  localparam int cnt_w = $clog2(bit_period);
  localparam int idx_w = $clog2(uart_pkg::frame_bits);

  logic [uart_pkg::frame_bits-1:0] shreg;
  logic [cnt_w-1:0]                cnt;
  logic [idx_w-1:0]                idx;
  logic                            busy;

  // Line idles high since ones are shifted in behind the frame
  assign tx          = shreg[0];
  assign phy.tx_busy = busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg <= '1;
      busy  <= 1'b0;
      cnt   <= '0;
      idx   <= '0;
    end
    else if (!busy)
    begin
      if (phy.tx_start)
      begin
        // Stop, even parity, data LSB first, start
        shreg <= {1'b1, ^phy.tx_byte, phy.tx_byte, 1'b0};
        busy  <= 1'b1;
        cnt   <= '0;
        idx   <= '0;
      end
    end
    else if (cnt == cnt_w'(bit_period - 1))
    begin
      cnt   <= '0;
      shreg <= {1'b1, shreg[uart_pkg::frame_bits-1:1]};
      if (idx == idx_w'(uart_pkg::frame_bits - 1))
      begin
        busy <= 1'b0;
      end
      else
      begin
        idx <= idx + 1'b1;
      end
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int bit_period = 434
) (
  input  logic   clk,
  input  logic   rst_n,
  uart_phy_if.rx phy,
  input  logic   rx
);

  localparam int cnt_w      = $clog2(bit_period);
  localparam int idx_w      = $clog2(uart_pkg::frame_bits);
  localparam int parity_idx = uart_pkg::frame_bits - 2;
  localparam int stop_idx   = uart_pkg::frame_bits - 1;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             active;
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] limit;
  logic [idx_w-1:0] idx;
  logic             sample;
  logic             par_bit;
  uart_pkg::byte_t  data;
  logic             done;
  logic             bad;

  // Half a bit to the centre of the start bit, then full bits
  assign limit  = (idx == '0) ? cnt_w'(bit_period / 2 - 1) : cnt_w'(bit_period - 1);
  assign sample = active && (cnt == limit);

  assign phy.rx_done = done;
  assign phy.rx_byte = data;
  assign phy.rx_bad  = bad;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      cnt     <= '0;
      idx     <= '0;
      par_bit <= 1'b0;
      done    <= 1'b0;
      bad     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (!active)
      begin
        if (phy.rx_arm && rx_prev && !rx_sync)
        begin
          active <= 1'b1;
          cnt    <= '0;
          idx    <= '0;
        end
      end
      else if (sample)
      begin
        cnt <= '0;
        if (idx == '0)
        begin
          // Start bit gone high again, treat as a glitch
          if (rx_sync)
          begin
            active <= 1'b0;
          end
          else
          begin
            idx <= idx + 1'b1;
          end
        end
        else if (idx == idx_w'(parity_idx))
        begin
          par_bit <= rx_sync;
          idx     <= idx + 1'b1;
        end
        else if (idx == idx_w'(stop_idx))
        begin
          active <= 1'b0;
          done   <= 1'b1;
          bad    <= (par_bit != ^data) || !rx_sync;
        end
        else
        begin
          idx <= idx + 1'b1;
        end
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk)
  begin
    if (sample && (idx != '0) && (idx < idx_w'(parity_idx)))
    begin
      data <= {rx_sync, data[7:1]};
    end
  end

endmodule

// File: hw/uart_ctrl.sv
`timescale 1ns/1ps

module uart_ctrl #(
  parameter int bit_period = 434
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_head,
  input  logic            cmd_avail,
  output logic            cmd_pop,
  uart_phy_if.ctrl        phy,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_err
);

  localparam int gap_w = $clog2(bit_period);

  uart_pkg::ctrl_state_t state;
  uart_pkg::addr_t       cmd_addr;
  uart_pkg::byte_t       wr_data;
  logic                  is_write;
  logic [gap_w-1:0]      gap_cnt;
  logic                  tx_idle;
  logic                  start_cmd;
  logic                  start_data;

  assign cmd_addr   = cmd_head[14:8];
  // No start pending and the frame has dropped busy
  assign tx_idle    = !phy.tx_start && !phy.tx_busy;
  assign start_cmd  = (state == uart_pkg::idle) && cmd_avail;
  // Counter starts at 1 so tx_start lands bit_period clocks after busy falls
  assign start_data = (state == uart_pkg::gap) && (gap_cnt == gap_w'(bit_period - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= uart_pkg::idle;
      cmd_pop      <= 1'b0;
      phy.tx_start <= 1'b0;
      phy.rx_arm   <= 1'b0;
      is_write     <= 1'b0;
      gap_cnt      <= '0;
      read_data    <= '0;
      read_rdy     <= 1'b0;
      read_err     <= 1'b0;
    end
    else
    begin
      cmd_pop      <= 1'b0;
      phy.tx_start <= 1'b0;
      read_rdy     <= 1'b0;
      read_err     <= 1'b0;
      case (state)
        uart_pkg::idle:
        begin
          if (start_cmd)
          begin
            cmd_pop      <= 1'b1;
            phy.tx_start <= 1'b1;
            is_write     <= cmd_head[15];
            // Armed early so a prompt reply is not missed
            phy.rx_arm   <= !cmd_head[15];
            state        <= uart_pkg::send_cmd;
          end
        end
        uart_pkg::send_cmd:
        begin
          if (tx_idle)
          begin
            if (is_write)
            begin
              gap_cnt <= gap_w'(1);
              state   <= uart_pkg::gap;
            end
            else
            begin
              state <= uart_pkg::wait_reply;
            end
          end
        end
        uart_pkg::gap:
        begin
          if (start_data)
          begin
            phy.tx_start <= 1'b1;
            state        <= uart_pkg::send_data;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_pkg::send_data:
        begin
          if (tx_idle)
          begin
            state <= uart_pkg::done;
          end
        end
        uart_pkg::wait_reply:
        begin
          if (phy.rx_done)
          begin
            read_data  <= phy.rx_byte;
            read_err   <= phy.rx_bad;
            read_rdy   <= 1'b1;
            phy.rx_arm <= 1'b0;
            state      <= uart_pkg::done;
          end
        end
        uart_pkg::done:
        begin
          state <= uart_pkg::idle;
        end
        default:
        begin
          state <= uart_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_cmd)
    begin
      phy.tx_byte <= {cmd_head[15], cmd_addr};
      wr_data     <= cmd_head[7:0];
    end
    else if (start_data)
    begin
      phy.tx_byte <= wr_data;
    end
  end

endmodule

// File: hw/uart.sv
`timescale 1ns/1ps

module uart #(
  parameter int bit_period = 434,
  parameter int fifo_depth = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  input  logic            rx,
  output logic            tx,
  output logic            cmd_rdy,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_err
);

  uart_pkg::cmd_t cmd_head;
  logic           cmd_avail;
  logic           cmd_pop;

  uart_phy_if phy ();

  cmd_fifo #(
    .fifo_depth (fifo_depth)
  ) i_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cmd_head  (cmd_head),
    .cmd_avail (cmd_avail),
    .cmd_pop   (cmd_pop)
  );

  uart_ctrl #(
    .bit_period (bit_period)
  ) i_uart_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_head  (cmd_head),
    .cmd_avail (cmd_avail),
    .cmd_pop   (cmd_pop),
    .phy       (phy.ctrl),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx #(
    .bit_period (bit_period)
  ) i_uart_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .phy   (phy.tx),
    .tx    (tx)
  );

  uart_rx #(
    .bit_period (bit_period)
  ) i_uart_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .phy   (phy.rx),
    .rx    (rx)
  );

endmodule

// File: tests/uart_asserts.sv
`timescale 1ns/1ps

module uart_asserts #(
  parameter int fifo_depth = 4
) (
  input logic clk,
  input logic rst_n,
  input logic tx,
  input logic read_rdy,
  input logic cmd_rdy,
  input logic cmd_vld,
  input logic cmd_pop,
  input logic cmd_avail
);

  int occupancy;

  // Queue fill level tracked from the push and pop handshakes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      occupancy <= 0;
    end
    else
    begin
      occupancy <= occupancy + int'(cmd_vld && cmd_rdy) - int'(cmd_pop && cmd_avail);
    end
  end

  tx_idle_in_reset: assert property (@(posedge clk) !rst_n |-> tx)
    else $error("tx low during reset");

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles");

  cmd_rdy_only_full: assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_rdy |-> (occupancy == fifo_depth))
    else $error("cmd_rdy low with free queue slots");

endmodule

// File: tests/tb_uart.sv
`timescale 1ns/1ps

module tb_uart;

  localparam int bit_period = 16;
  localparam int fifo_depth = 4;
  localparam int clk_period = 100;
  localparam int n_pairs    = 6;
  localparam int burst_len  = 12;
  localparam int num_cmds   = 2 * n_pairs + 2 + burst_len;

  logic            clk;
  logic            rst_n;
  uart_pkg::cmd_t  cmd_in;
  logic            cmd_vld;
  logic            rx;
  logic            tx;
  logic            cmd_rdy;
  uart_pkg::byte_t read_data;
  logic            read_rdy;
  logic            read_err;

  // Device registers and the reference copy
  uart_pkg::byte_t dev_regs [128];
  uart_pkg::byte_t ref_regs [128];
  uart_pkg::cmd_t  issued_q [$];
  logic [8:0]      exp_q [$];
  logic            corrupt_q [$];
  int              reads_issued;
  int              reads_done;
  logic            saw_full;

  uart #(
    .bit_period (bit_period),
    .fifo_depth (fifo_depth)
  ) i_uart (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  bind uart uart_asserts #(
    .fifo_depth (fifo_depth)
  ) i_uart_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .cmd_rdy   (cmd_rdy),
    .cmd_vld   (cmd_vld),
    .cmd_pop   (cmd_pop),
    .cmd_avail (cmd_avail)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic uart_pkg::byte_t fill_value(input uart_pkg::addr_t a);
    return 8'(a) * 8'd29 + 8'd7;
  endfunction

  // Expected {read_err, read_data} for a read and zero for a write
  function automatic logic [8:0] exp_read(input uart_pkg::cmd_t c, input logic corrupt);
    uart_pkg::addr_t a;
    a = c[14:8];
    if (c[15])
    begin
      ref_regs[a] = c[7:0];
      return 9'h0;
    end
    return {corrupt, ref_regs[a]};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected)
    begin
      stop_run($sformatf("FAIL time=%0t %s got 0x%0h expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  // Called and returns 10 ns after a rising edge
  task automatic issue_cmd(input uart_pkg::cmd_t c, input logic corrupt);
    logic [8:0] e;
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      saw_full = 1'b1;
      @(posedge clk);
      #10;
    end
    @(posedge clk);
    issued_q.push_back(c);
    e = exp_read(c, corrupt);
    if (!c[15])
    begin
      exp_q.push_back(e);
      corrupt_q.push_back(corrupt);
      reads_issued++;
    end
    #10;
    cmd_vld = 1'b0;
  endtask

  task automatic wait_reads();
    wait (reads_done == reads_issued);
    @(posedge clk);
    #10;
  endtask

  // Decode one frame on tx at mid-bit
  task automatic recv_frame(input string what, output uart_pkg::byte_t b);
    logic [uart_pkg::frame_bits-1:0] f;
    @(negedge tx);
    repeat (bit_period / 2) @(negedge clk);
    f[0] = tx;
    for (int i = 1; i < uart_pkg::frame_bits; i++)
    begin
      repeat (bit_period) @(negedge clk);
      f[i] = tx;
    end
    check_value({what, " start bit"}, 16'(f[0]), 16'd0);
    check_value({what, " parity bit"}, 16'(f[9]), 16'(^f[8:1]));
    check_value({what, " stop bit"}, 16'(f[10]), 16'd1);
    b = f[8:1];
  endtask

  task automatic send_reply(input uart_pkg::byte_t b, input logic corrupt);
    logic [uart_pkg::frame_bits-1:0] f;
    f = {1'b1, (^b) ^ corrupt, b, 1'b0};
    for (int i = 0; i < uart_pkg::frame_bits; i++)
    begin
      @(posedge clk);
      #10;
      rx = f[i];
      // Stop bit stays on the idle line after return
      if (i < uart_pkg::frame_bits - 1)
      begin
        repeat (bit_period - 1) @(posedge clk);
      end
    end
  endtask

  // Register device on the far side of the serial line
  initial
  begin
    uart_pkg::cmd_t  c;
    uart_pkg::byte_t b;
    logic [31:0]     dev_seed;
    int              delay;
    logic            corrupt;
    dev_seed = 32'd76;
    wait (rst_n === 1'b1);
    forever
    begin
      recv_frame("command byte", b);
      if (issued_q.size() == 0)
      begin
        stop_run("A frame appeared on tx with no command issued");
      end
      else
      begin
        c = issued_q.pop_front();
        check_value("command byte", 16'(b), 16'({c[15], c[14:8]}));
        if (c[15])
        begin
          recv_frame("data byte", b);
          check_value("data byte", 16'(b), 16'(c[7:0]));
          dev_regs[c[14:8]] = b;
        end
        else
        begin
          corrupt  = corrupt_q.pop_front();
          dev_seed = lcg_next(dev_seed);
          delay    = int'(dev_seed[23:16]) % 41;
          repeat (delay) @(posedge clk);
          send_reply(dev_regs[c[14:8]], corrupt);
        end
      end
    end
  end

  // Compare every read result against the expected queue
  initial
  begin
    logic [8:0] e;
    forever
    begin
      @(negedge clk);
      if (read_rdy === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          stop_run("read_rdy pulsed with no read outstanding");
        end
        else
        begin
          e = exp_q.pop_front();
          check_value("read_data", 16'(read_data), 16'(e[7:0]));
          check_value("read_err", 16'(read_err), 16'(e[8]));
          reads_done++;
        end
      end
    end
  end

  initial
  begin
    #(num_cmds * 40 * bit_period * clk_period);
    stop_run("Watchdog expired before all commands completed");
  end

  initial
  begin
    uart_pkg::addr_t a;
    uart_pkg::byte_t d;
    uart_pkg::addr_t pool [8];
    logic [31:0]     stim_seed;
    logic            wr;
    stim_seed    = 32'd76;
    reads_issued = 0;
    reads_done   = 0;
    saw_full     = 1'b0;
    for (int i = 0; i < 128; i++)
    begin
      dev_regs[i] = fill_value(7'(i));
      ref_regs[i] = fill_value(7'(i));
    end
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    rst_n   = 1'b1;
    #10;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;

    check_value("tx", 16'(tx), 16'd1);
    check_value("cmd_rdy", 16'(cmd_rdy), 16'd1);
    check_value("read_rdy", 16'(read_rdy), 16'd0);

    // Write then read back
    a = '0;
    for (int i = 0; i < n_pairs; i++)
    begin
      stim_seed = lcg_next(stim_seed);
      a         = stim_seed[22:16];
      d         = stim_seed[30:23];
      issue_cmd({1'b1, a, d}, 1'b0);
      issue_cmd({1'b0, a, 8'h00}, 1'b0);
    end
    wait_reads();

    // Bad parity on one reply and a clean one next
    issue_cmd({1'b0, a, 8'h00}, 1'b1);
    issue_cmd({1'b0, a, 8'h00}, 1'b0);
    wait_reads();

    // Burst faster than the line drains it
    for (int i = 0; i < 8; i++)
    begin
      stim_seed = lcg_next(stim_seed);
      pool[i]   = stim_seed[22:16];
    end
    saw_full = 1'b0;
    for (int i = 0; i < burst_len; i++)
    begin
      stim_seed = lcg_next(stim_seed);
      wr        = stim_seed[31] && (i != burst_len - 1);
      issue_cmd({wr, pool[stim_seed[18:16]], stim_seed[27:20]}, 1'b0);
    end
    check_value("cmd_rdy low during burst", 16'(saw_full), 16'd1);
    wait_reads();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: all.f
hw/uart_pkg.sv
hw/uart_phy_if.sv
hw/cmd_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_ctrl.sv
hw/uart.sv
tests/uart_asserts.sv
tests/tb_uart.sv

// File: Makefile
TOP := tb_uart

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
